// File: all.f
+incdir+design
design/tau_pkg.sv
design/tau_if.sv
design/block_looper.sv
design/addr_gen.sv
design/dram_reader.sv
design/tile_writer.sv
design/tau_top.sv
test/tau_assert.sv
test/tb_top.sv

// File: design/addr_gen.sv
// ==========================================================
// address generator
//   block offset -> read/write line address and
//   boundary write mask, one-entry output slot
// ==========================================================

`include "tau_defines.svh"
`timescale 1ns/1ps

module addr_gen (
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  tau_pkg::gaddr_t i_rd_base,
	input  tau_pkg::gaddr_t i_wr_base,
	input  tau_pkg::gaddr_t i_row_pitch,
	input  tau_pkg::work_t  i_bgrid_end_x,
	blk_if.dst              i_blk,
	line_if.src             o_line
);
	import tau_pkg::*;

	logic              vld;
	logic              in_xfer;
	gaddr_t            blk_ofs;  // ofs_y * pitch + ofs_x
	mask_t             mask_d;
	logic [`TAU_WBW:0] col;

	// take a new block when the slot is empty or draining this cycle
	assign i_blk.ack = i_blk.rdy & (~vld | o_line.ack);
	assign in_xfer   = i_blk.rdy & i_blk.ack;

	assign blk_ofs = gaddr_t'(i_blk.ofs_y) * i_row_pitch + gaddr_t'(i_blk.ofs_x);

	always_comb begin
		mask_d = '0;
		col    = '0;
		for (int k = 0; k < `TAU_CSIZE; k++) begin
			col       = {1'b0, i_blk.ofs_x} + (`TAU_WBW+1)'(k);
			mask_d[k] = col < {1'b0, i_bgrid_end_x}; // clear words past the x end
		end
	end

	assign o_line.rdy  = vld;
	assign o_line.data = '0; // no line data before the read

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			vld <= 1'b0;
		end else if (in_xfer) begin
			vld <= 1'b1;
		end else if (o_line.ack) begin
			vld <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (in_xfer) begin
			o_line.rd_addr <= i_rd_base + blk_ofs;
			o_line.wr_addr <= i_wr_base + blk_ofs;
			o_line.mask    <= mask_d;
		end
	end

endmodule

// File: design/block_looper.sv
// ==========================================================
// block looper
//   job handshake, 2-d grid walk with x innermost,
//   in-flight block count and job completion
// ==========================================================

`include "tau_defines.svh"
`timescale 1ns/1ps

module block_looper (
	input  logic           i_clk,
	input  logic           i_rst_n,
	input  logic           i_src_rdy,
	output logic           o_src_ack,
	input  tau_pkg::work_t i_bgrid_step_x,
	input  tau_pkg::work_t i_bgrid_step_y,
	input  tau_pkg::work_t i_bgrid_end_x,
	input  tau_pkg::work_t i_bgrid_end_y,
	input  logic           i_blk_done,
	blk_if.src             o_blk
);
	import tau_pkg::*;

	looper_state_e     state;
	logic [2:0]        n_inflight; // issued but not yet written back
	logic [`TAU_WBW:0] nx_sum;     // one extra bit so the compare cannot wrap
	logic [`TAU_WBW:0] ny_sum;
	logic              xfer;
	logic              row_end;
	logic              last_blk;

	assign xfer     = o_blk.rdy & o_blk.ack;
	assign nx_sum   = {1'b0, o_blk.ofs_x} + {1'b0, i_bgrid_step_x};
	assign ny_sum   = {1'b0, o_blk.ofs_y} + {1'b0, i_bgrid_step_y};
	assign row_end  = nx_sum >= {1'b0, i_bgrid_end_x};
	assign last_blk = row_end && (ny_sum >= {1'b0, i_bgrid_end_y});

	assign o_blk.rdy = (state == L_RUN);
	assign o_src_ack = (state == L_DRAIN) && (n_inflight == '0); // one cycle, then IDLE

	// ==========================================================
	// job control
	// ==========================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= L_IDLE;
		end else begin
			case (state)
				L_IDLE:  if (i_src_rdy) state <= L_RUN;
				L_RUN:   if (xfer && last_blk) state <= L_DRAIN;
				L_DRAIN: if (n_inflight == '0) state <= L_IDLE;
				default: state <= L_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			n_inflight <= '0;
		end else begin
			case ({xfer, i_blk_done})
				2'b10:   n_inflight <= n_inflight + 3'd1;
				2'b01:   n_inflight <= n_inflight - 3'd1;
				default: n_inflight <= n_inflight; // both or neither
			endcase
		end
	end

	// grid walk, restarts at the origin while idle
	always_ff @(posedge i_clk) begin
		if (state == L_IDLE) begin
			o_blk.ofs_x <= '0;
			o_blk.ofs_y <= '0;
		end else if (xfer) begin
			if (row_end) begin
				o_blk.ofs_x <= '0;
				o_blk.ofs_y <= ny_sum[`TAU_WBW-1:0];
			end else begin
				o_blk.ofs_x <= nx_sum[`TAU_WBW-1:0];
			end
		end
	end

endmodule

// File: design/dram_reader.sv
// ==========================================================
// DRAM reader
//   sends the read address, waits for the line and
//   hands it on with write address and mask
// ==========================================================

`timescale 1ns/1ps

module dram_reader (
	input  logic            i_clk,
	input  logic            i_rst_n,
	line_if.dst             i_line,
	line_if.src             o_line,
	output logic            o_dramra_rdy,
	input  logic            i_dramra_ack,
	output tau_pkg::gaddr_t o_dramra,
	input  logic            i_dramrd_rdy,
	output logic            o_dramrd_ack,
	input  tau_pkg::line_t  i_dramrd
);
	import tau_pkg::*;

	reader_state_e state;
	gaddr_t        rd_addr;
	logic          out_vld;
	logic          in_xfer;
	logic          rd_done;

	// only one item per stage, so wait for the output slot to drain
	assign i_line.ack = i_line.rdy && (state == R_IDLE) && (!out_vld || o_line.ack);
	assign in_xfer    = i_line.rdy & i_line.ack;

	assign o_dramra_rdy = (state == R_REQ);
	assign o_dramra     = rd_addr;
	assign o_dramrd_ack = (state == R_WAIT) && i_dramrd_rdy;
	assign rd_done      = o_dramrd_ack;

	assign o_line.rdy     = out_vld;
	assign o_line.rd_addr = rd_addr;

	// ==========================================================
	// read sequencing
	// ==========================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= R_IDLE;
		end else begin
			case (state)
				R_IDLE:  if (in_xfer) state <= R_REQ;
				R_REQ:   if (i_dramra_ack) state <= R_WAIT;
				R_WAIT:  if (rd_done) state <= R_IDLE;
				default: state <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			out_vld <= 1'b0;
		end else if (rd_done) begin
			out_vld <= 1'b1;
		end else if (o_line.ack) begin
			out_vld <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (in_xfer) begin
			rd_addr        <= i_line.rd_addr;
			o_line.wr_addr <= i_line.wr_addr;
			o_line.mask    <= i_line.mask;
		end
		if (rd_done) o_line.data <= i_dramrd; // returned line, in order
	end

endmodule

// File: design/tau_defines.svh
// ==========================================================
// global widths and sizes for the tile unit datapath
// word, DRAM address, grid coordinate, words per line
// ==========================================================

`ifndef TAU_DEFINES_SVH
`define TAU_DEFINES_SVH

// ==========================================================
// datapath widths
// ==========================================================
`define TAU_DBW   16 // one data word
`define TAU_GBW   16 // DRAM line address
`define TAU_WBW   8  // grid coordinate / step

// cache line geometry
`define TAU_CSIZE 4  // words per line

`endif

// File: design/tau_if.sv
// ==========================================================
// rdy/ack channels between pipeline stages
//   blk_if  : block offset from the looper
//   line_if : addresses, mask and line data
// ==========================================================

`timescale 1ns/1ps

interface blk_if;
	logic           rdy;
	logic           ack;
	tau_pkg::work_t ofs_x;
	tau_pkg::work_t ofs_y;

	modport src (output rdy, ofs_x, ofs_y, input ack);
	modport dst (input rdy, ofs_x, ofs_y, output ack);
endinterface

interface line_if;
	logic            rdy;
	logic            ack;
	tau_pkg::gaddr_t wr_addr;
	tau_pkg::mask_t  mask;
	tau_pkg::gaddr_t rd_addr; // only meaningful before the read
	tau_pkg::line_t  data;    // only meaningful after the read

	modport src (
		output rdy, wr_addr, mask, rd_addr, data,
		input  ack
	);
	modport dst (
		input  rdy, wr_addr, mask, rd_addr, data,
		output ack
	);
endinterface

// File: design/tau_pkg.sv
// ==========================================================
// shared vector typedefs and FSM state enums
// ==========================================================

`include "tau_defines.svh"

package tau_pkg;

	typedef logic [`TAU_DBW-1:0]            data_t;
	typedef logic [`TAU_GBW-1:0]            gaddr_t;
	typedef logic [`TAU_WBW-1:0]            work_t;
	typedef logic [`TAU_CSIZE*`TAU_DBW-1:0] line_t;  // word 0 in low bits
	typedef logic [`TAU_CSIZE-1:0]          mask_t;  // one write enable per word

	// block looper job control
	typedef enum logic [1:0] {L_IDLE, L_RUN, L_DRAIN} looper_state_e;

	// dram reader, one outstanding read
	typedef enum logic [1:0] {R_IDLE, R_REQ, R_WAIT} reader_state_e;

	typedef enum logic {W_IDLE, W_WRITE} writer_state_e;

endpackage

// File: design/tau_top.sv
// ==========================================================
// single-cluster tile unit top
//   looper -> address gen -> DRAM reader -> writer,
//   plain ports for job config and the DRAM channels
// ==========================================================

`timescale 1ns/1ps

module tau_top (
	input  logic            i_clk,
	input  logic            i_rst_n,
	// job handshake and config, stable while i_src_rdy
	input  logic            i_src_rdy,
	output logic            o_src_ack,
	input  tau_pkg::work_t  i_bgrid_step_x,
	input  tau_pkg::work_t  i_bgrid_step_y,
	input  tau_pkg::work_t  i_bgrid_end_x,
	input  tau_pkg::work_t  i_bgrid_end_y,
	input  tau_pkg::gaddr_t i_rd_base,
	input  tau_pkg::gaddr_t i_wr_base,
	input  tau_pkg::gaddr_t i_row_pitch,
	input  tau_pkg::data_t  i_const,
	// DRAM read address
	output logic            o_dramra_rdy,
	input  logic            i_dramra_ack,
	output tau_pkg::gaddr_t o_dramra,
	// DRAM read data
	input  logic            i_dramrd_rdy,
	output logic            o_dramrd_ack,
	input  tau_pkg::line_t  i_dramrd,
	// DRAM write
	output logic            o_dramw_rdy,
	input  logic            i_dramw_ack,
	output tau_pkg::gaddr_t o_dramwa,
	output tau_pkg::line_t  o_dramwd,
	output tau_pkg::mask_t  o_dramw_mask
);

	// ==========================================================
	// stage channels
	// ==========================================================
	blk_if  blk_ch ();
	line_if ag2rd ();  // addresses and mask only
	line_if rd2wr ();  // line data with write address

	logic blk_done;

	block_looper u_looper (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_src_rdy      (i_src_rdy),
		.o_src_ack      (o_src_ack),
		.i_bgrid_step_x (i_bgrid_step_x),
		.i_bgrid_step_y (i_bgrid_step_y),
		.i_bgrid_end_x  (i_bgrid_end_x),
		.i_bgrid_end_y  (i_bgrid_end_y),
		.i_blk_done     (blk_done),
		.o_blk          (blk_ch.src)
	);

	addr_gen u_agen (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_rd_base     (i_rd_base),
		.i_wr_base     (i_wr_base),
		.i_row_pitch   (i_row_pitch),
		.i_bgrid_end_x (i_bgrid_end_x),
		.i_blk         (blk_ch.dst),
		.o_line        (ag2rd.src)
	);

	dram_reader u_reader (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_line       (ag2rd.dst),
		.o_line       (rd2wr.src),
		.o_dramra_rdy (o_dramra_rdy),
		.i_dramra_ack (i_dramra_ack),
		.o_dramra     (o_dramra),
		.i_dramrd_rdy (i_dramrd_rdy),
		.o_dramrd_ack (o_dramrd_ack),
		.i_dramrd     (i_dramrd)
	);

	tile_writer u_writer (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_const      (i_const),
		.i_line       (rd2wr.dst),
		.o_dramw_rdy  (o_dramw_rdy),
		.i_dramw_ack  (i_dramw_ack),
		.o_dramwa     (o_dramwa),
		.o_dramwd     (o_dramwd),
		.o_dramw_mask (o_dramw_mask),
		.o_blk_done   (blk_done)
	);

endmodule

// File: design/tile_writer.sv
// ==========================================================
// tile writer
//   adds the job constant to every word and issues the
//   masked line write, pulses block done on the write
// ==========================================================

`include "tau_defines.svh"
`timescale 1ns/1ps

module tile_writer (
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  tau_pkg::data_t  i_const,
	line_if.dst             i_line,
	output logic            o_dramw_rdy,
	input  logic            i_dramw_ack,
	output tau_pkg::gaddr_t o_dramwa,
	output tau_pkg::line_t  o_dramwd,
	output tau_pkg::mask_t  o_dramw_mask,
	output logic            o_blk_done
);
	import tau_pkg::*;

	writer_state_e state;
	line_t         sum;
	logic          in_xfer;

	assign o_dramw_rdy = (state == W_WRITE);
	assign o_blk_done  = o_dramw_rdy & i_dramw_ack;

	// a new line may enter while the current write completes
	assign i_line.ack = i_line.rdy & ((state == W_IDLE) | o_blk_done);
	assign in_xfer    = i_line.rdy & i_line.ack;

	// ==========================================================
	// per-word add, wraps at the word width
	// ==========================================================
	always_comb begin
		for (int k = 0; k < `TAU_CSIZE; k++) begin
			sum[k*`TAU_DBW +: `TAU_DBW] = i_line.data[k*`TAU_DBW +: `TAU_DBW] + i_const;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= W_IDLE;
		end else begin
			case (state)
				W_IDLE: begin
					if (in_xfer) state <= W_WRITE;
				end
				W_WRITE: begin
					if (o_blk_done && !in_xfer) state <= W_IDLE; // else refilled
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	// write payload, held until the DRAM takes it
	always_ff @(posedge i_clk) begin
		if (in_xfer) begin
			o_dramwa     <= i_line.wr_addr;
			o_dramwd     <= sum;
			o_dramw_mask <= i_line.mask;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the tile unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_top -Mdir obj_dir -f all.f; then
	echo "verilator build failed"
	exit 1
fi

# let the testbench see handshake checker failures before the simulator stops
out=$(./obj_dir/Vtb_top +verilator+error+limit+100)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: test/tau_assert.sv
// ==========================================================
// handshake checks bound into the tile unit top
//   DRAM channels hold rdy and payload until ack,
//   acks only with rdy, single-cycle job acknowledge
// ==========================================================

`timescale 1ns/1ps

module tau_assert (
	input logic            i_clk,
	input logic            i_rst_n,
	input logic            i_src_ack,
	input logic            i_dramra_rdy,
	input logic            i_dramra_ack,
	input tau_pkg::gaddr_t i_dramra,
	input logic            i_dramrd_rdy,
	input logic            i_dramrd_ack,
	input tau_pkg::line_t  i_dramrd,
	input logic            i_dramw_rdy,
	input logic            i_dramw_ack,
	input tau_pkg::gaddr_t i_dramwa,
	input tau_pkg::line_t  i_dramwd,
	input tau_pkg::mask_t  i_dramw_mask
);

	int n_fail = 0; // number of failed checks so far

	// ==========================================================
	// hold until ack on the three DRAM channels
	// ==========================================================
	a_ra_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_dramra_rdy && !i_dramra_ack) |=> (i_dramra_rdy && $stable(i_dramra)))
		else begin $error("read address dropped or changed before ack"); n_fail++; end

	a_rd_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_dramrd_rdy && !i_dramrd_ack) |=> (i_dramrd_rdy && $stable(i_dramrd)))
		else begin $error("read data dropped or changed before ack"); n_fail++; end

	a_w_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_dramw_rdy && !i_dramw_ack) |=> (i_dramw_rdy && $stable(i_dramwa)
			&& $stable(i_dramwd) && $stable(i_dramw_mask)))
		else begin $error("write dropped or changed before ack"); n_fail++; end

	// ack only while the producer offers
	a_rd_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dramrd_ack |-> i_dramrd_rdy)
		else begin $error("read data ack without rdy"); n_fail++; end

	a_ra_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dramra_ack |-> i_dramra_rdy)
		else begin $error("read address ack without rdy"); n_fail++; end

	a_src_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_src_ack |=> !i_src_ack)
		else begin $error("job ack longer than one cycle"); n_fail++; end

endmodule

bind tau_top tau_assert u_chk (
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_src_ack    (o_src_ack),
	.i_dramra_rdy (o_dramra_rdy),
	.i_dramra_ack (i_dramra_ack),
	.i_dramra     (o_dramra),
	.i_dramrd_rdy (i_dramrd_rdy),
	.i_dramrd_ack (o_dramrd_ack),
	.i_dramrd     (i_dramrd),
	.i_dramw_rdy  (o_dramw_rdy),
	.i_dramw_ack  (i_dramw_ack),
	.i_dramwa     (o_dramwa),
	.i_dramwd     (o_dramwd),
	.i_dramw_mask (o_dramw_mask)
);

// File: test/tb_top.sv
// ==========================================================
// testbench for the tile unit top
//   clock/reset, DRAM model with random ack delays,
//   job stimulus, write scoreboard and timeout
// ==========================================================

`include "tau_defines.svh"
`timescale 1ns/1ps

module tb_top;
	import tau_pkg::*;

	// 33 blocks in all, each well under 40 cycles even with 3-cycle stalls, x3 margin
	localparam int TIMEOUT_CYCLES = 4000;

	logic   clk;
	logic   rst_n;
	logic   src_rdy;
	logic   src_ack;
	work_t  step_x, step_y, end_x, end_y;
	gaddr_t rd_base, wr_base, row_pitch;
	data_t  add_const;
	logic   dramra_rdy;
	logic   dramra_ack = 1'b0;
	gaddr_t dramra;
	logic   dramrd_rdy = 1'b0;
	logic   dramrd_ack;
	line_t  dramrd = '0;
	logic   dramw_rdy;
	logic   dramw_ack = 1'b0;
	gaddr_t dramwa;
	line_t  dramwd;
	mask_t  dramw_mask;

	integer     seed = 51335;
	logic [1:0] ra_wait = 2'd0; // cycles left before each DRAM ack
	logic [1:0] rd_wait = 2'd0;
	logic [1:0] w_wait = 2'd0;
	int         cycle_cnt = 0;
	int         n_reads = 0;
	int         n_acks = 0;
	string      test_name = "reset";
	gaddr_t     exp_addr[$];   // scoreboard, one entry per expected write
	mask_t      exp_mask[$];
	line_t      exp_data[$];
	gaddr_t     rd_pending[$]; // read addresses taken, line not yet returned

	tau_top DUT (
		.i_clk (clk), .i_rst_n (rst_n),
		.i_src_rdy (src_rdy), .o_src_ack (src_ack),
		.i_bgrid_step_x (step_x), .i_bgrid_step_y (step_y),
		.i_bgrid_end_x (end_x), .i_bgrid_end_y (end_y),
		.i_rd_base (rd_base), .i_wr_base (wr_base),
		.i_row_pitch (row_pitch), .i_const (add_const),
		.o_dramra_rdy (dramra_rdy), .i_dramra_ack (dramra_ack), .o_dramra (dramra),
		.i_dramrd_rdy (dramrd_rdy), .o_dramrd_ack (dramrd_ack), .i_dramrd (dramrd),
		.o_dramw_rdy (dramw_rdy), .i_dramw_ack (dramw_ack), .o_dramwa (dramwa),
		.o_dramwd (dramwd), .o_dramw_mask (dramw_mask)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [1:0] rand_delay();
		logic [31:0] r;
		r = $random(seed);
		return r[1:0];
	endfunction

	// DRAM content: word k of a line is address*8 + k
	function automatic data_t line_word(input gaddr_t a, input int k);
		logic [31:0] v;
		v = 32'(a) * 32'd8 + 32'(k);
		return v[`TAU_DBW-1:0];
	endfunction

	function automatic line_t line_for(input gaddr_t a);
		line_t l;
		for (int k = 0; k < `TAU_CSIZE; k++) l[k*`TAU_DBW +: `TAU_DBW] = line_word(a, k);
		return l;
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		$display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp_v, act_v);
		$display("SOME TESTS FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic check_write();
		if (exp_addr.size() == 0) begin
			$display("%s: DRAM write to 0x%0h when none was expected", test_name, dramwa);
			$display("SOME TESTS FAILED");
			$fatal(1, "unexpected write");
		end else begin
			assert (dramwa == exp_addr[0])
				else report_mismatch("write address", 64'(exp_addr[0]), 64'(dramwa));
			assert (dramw_mask == exp_mask[0])
				else report_mismatch("write mask", 64'(exp_mask[0]), 64'(dramw_mask));
			assert (dramwd == exp_data[0])
				else report_mismatch("write data", 64'(exp_data[0]), 64'(dramwd));
			void'(exp_addr.pop_front());
			void'(exp_mask.pop_front());
			void'(exp_data.pop_front());
		end
	endtask

	// ==========================================================
	// DRAM model, one process so the random sequence is fixed
	// ==========================================================
	always @(posedge clk) begin
		if (rst_n) begin
			if (dramra_rdy && dramra_ack) begin
				rd_pending.push_back(dramra);
				n_reads++;
			end
			if (dramra_ack) begin
				dramra_ack <= 1'b0;
				ra_wait    <= rand_delay();
			end else if (dramra_rdy) begin
				if (ra_wait == 2'd0) dramra_ack <= 1'b1;
				else ra_wait <= ra_wait - 2'd1;
			end
			if (dramrd_rdy) begin
				if (dramrd_ack) begin
					dramrd_rdy <= 1'b0;
					rd_wait    <= rand_delay();
				end
			end else if (rd_pending.size() != 0) begin
				if (rd_wait == 2'd0) begin
					dramrd_rdy <= 1'b1;
					dramrd     <= line_for(rd_pending.pop_front());
				end else begin
					rd_wait <= rd_wait - 2'd1;
				end
			end
			if (dramw_rdy && dramw_ack) check_write();
			if (dramw_ack) begin
				dramw_ack <= 1'b0;
				w_wait    <= rand_delay();
			end else if (dramw_rdy) begin
				if (w_wait == 2'd0) dramw_ack <= 1'b1;
				else w_wait <= w_wait - 2'd1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (rst_n && src_ack) n_acks++;
		if (DUT.u_chk.n_fail != 0) begin
			$display("%s: a handshake assertion failed", test_name);
			$display("SOME TESTS FAILED");
			$fatal(1, "handshake assertion");
		end
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	// expected writes in x-then-y order, then one job handshake
	task automatic run_job(input string name, input work_t sx, input work_t sy,
		input work_t ex, input work_t ey, input gaddr_t rb, input gaddr_t wb,
		input gaddr_t pitch, input data_t c);
		int     ex_i, ey_i, sx_i, sy_i;
		int     n_blk, reads_before, acks_before;
		gaddr_t ra, wa;
		mask_t  m;
		line_t  d;
		test_name = name;
		ex_i = int'(ex);
		ey_i = int'(ey);
		sx_i = int'(sx);
		sy_i = int'(sy);
		n_blk = 0;
		for (int y = 0; y < ey_i; y += sy_i) begin
			for (int x = 0; x < ex_i; x += sx_i) begin
				ra = rb + gaddr_t'(y) * pitch + gaddr_t'(x);
				wa = wb + gaddr_t'(y) * pitch + gaddr_t'(x);
				for (int k = 0; k < `TAU_CSIZE; k++) begin
					m[k] = (x + k) < ex_i; // words past the x end stay unwritten
					d[k*`TAU_DBW +: `TAU_DBW] = line_word(ra, k) + c;
				end
				exp_addr.push_back(wa);
				exp_mask.push_back(m);
				exp_data.push_back(d);
				n_blk++;
			end
		end
		reads_before = n_reads;
		acks_before  = n_acks;
		@(posedge clk);
		step_x    <= sx;
		step_y    <= sy;
		end_x     <= ex;
		end_y     <= ey;
		rd_base   <= rb;
		wr_base   <= wb;
		row_pitch <= pitch;
		add_const <= c;
		src_rdy   <= 1'b1;
		do @(posedge clk); while (!src_ack);
		src_rdy <= 1'b0;
		@(posedge clk);
		@(negedge clk); // read and ack counters settled
		assert (exp_addr.size() == 0)
			else report_mismatch("writes left at ack", 64'd0, 64'(exp_addr.size()));
		assert (n_reads - reads_before == n_blk)
			else report_mismatch("read count", 64'(n_blk), 64'(n_reads - reads_before));
		assert (n_acks - acks_before == 1)
			else report_mismatch("job ack count", 64'd1, 64'(n_acks - acks_before));
	endtask

	initial begin
		rst_n     = 1'b0;
		src_rdy   = 1'b0;
		step_x    = '0;
		step_y    = '0;
		end_x     = '0;
		end_y     = '0;
		rd_base   = '0;
		wr_base   = '0;
		row_pitch = '0;
		add_const = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		run_job("single_block", 8'd4, 8'd1, 8'd4, 8'd1, 16'h0100, 16'h2000, 16'h0040, 16'h0011);
		run_job("multi_block", 8'd4, 8'd4, 8'd12, 8'd8, 16'h0200, 16'h3000, 16'h0020, 16'h0005);
		run_job("boundary_mask", 8'd4, 8'd1, 8'd10, 8'd2, 16'h0400, 16'h3800, 16'h0010,
			16'h0100);
		run_job("wraparound", 8'd4, 8'd1, 8'd8, 8'd1, 16'h1FFE, 16'h5000, 16'h0010, 16'hFFF8);
		run_job("back_pressure", 8'd4, 8'd2, 8'd16, 8'd6, 16'h0800, 16'h4000, 16'h0100,
			16'h1234);
		run_job("back_to_back_a", 8'd4, 8'd1, 8'd8, 8'd2, 16'h0040, 16'h6000, 16'h0008,
			16'h0003);
		run_job("back_to_back_b", 8'd4, 8'd3, 8'd6, 8'd3, 16'h0090, 16'h7000, 16'h0010,
			16'h00F0);
		@(posedge clk);
		if (DUT.u_chk.n_fail == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "handshake assertion");
		end
	end

endmodule
